// File: matmul_pkg.sv
`default_nettype none

package matmul_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and fixed tile geometry
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH   = 8;
    localparam int ARRAY_SIZE   = 4;
    localparam int ADDR_WIDTH   = 10;
    localparam int STRIDE_WIDTH = 8;
    localparam int STEP_WIDTH   = 8;

    // Operand register, product register and accumulator
    localparam int MAC_STAGES   = 3;
    localparam int MEM_LATENCY  = 1;

    ////////////////////////////////////////////////////////////
    // Cycle constants of one 4x4 multiply
    ////////////////////////////////////////////////////////////

    // The last operand pair enters PE33 in step 3N-1 and its product
    // reaches the accumulator MAC_STAGES cycles later
    localparam int ROW_LATCH_STEP = 3 * ARRAY_SIZE - 1 + MAC_STAGES;
    localparam int DONE_STEP      = ROW_LATCH_STEP + MAC_STAGES;

    typedef logic [DATA_WIDTH-1:0]            data_t;
    typedef logic [ARRAY_SIZE*DATA_WIDTH-1:0] lane_vec_t;
    typedef logic [ADDR_WIDTH-1:0]            addr_t;
    typedef logic [STRIDE_WIDTH-1:0]          stride_t;
    typedef logic [ARRAY_SIZE-1:0]            mask_t;
    typedef logic [STEP_WIDTH-1:0]            step_t;

    typedef enum logic
    {
        DRAIN_IDLE,
        DRAIN_SHIFT
    } drain_state_t;

endpackage

`default_nettype wire

// File: matmul_sequencer.sv
`default_nettype none

module matmul_sequencer
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  start_mat_mul,
    output step_t step,
    output logic  done_mat_mul
);

    ////////////////////////////////////////////////////////////
    // Step counter and done pulse
    ////////////////////////////////////////////////////////////

    // The count sits at zero while start is low, so the first cycle
    // with start high is step 0
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            step         <= '0;
            done_mat_mul <= 1'b0;
        end
        else
        begin
            step         <= step + 1'b1;
            // Done shows up one cycle after the count passes DONE_STEP
            done_mat_mul <= (step == step_t'(DONE_STEP));
        end
    end

    // Done is a single-cycle pulse per operation
    a_done_one_cycle : assert property (
        @(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul
    );

endmodule

`default_nettype wire

// File: operand_feeder.sv
`default_nettype none

module operand_feeder
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  step_t     step,
    input  addr_t     base_addr,
    input  stride_t   addr_stride,
    input  lane_vec_t mem_data,
    input  mask_t     step_mask,
    input  mask_t     lane_mask,
    output addr_t     mem_addr,
    output lane_vec_t skewed_lanes
);

    logic                        mem_access;
    logic [$clog2(ARRAY_SIZE):0] access_cnt;
    logic                        arrival_valid;
    logic                        skew_clear;
    data_t                       masked [ARRAY_SIZE];

    ////////////////////////////////////////////////////////////
    // Read address walk
    ////////////////////////////////////////////////////////////

    // Idle address sits one stride below the base so the first
    // increment lands on the base in step 1
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || step >= step_t'(ARRAY_SIZE))
        begin
            mem_addr   <= base_addr - addr_t'(addr_stride);
            mem_access <= 1'b0;
        end
        else
        begin
            mem_addr   <= mem_addr + addr_t'(addr_stride);
            mem_access <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Arrival tracking
    ////////////////////////////////////////////////////////////

    // Counts addresses already presented, so a value of k+1 means
    // read k is on mem_data this cycle
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
            access_cnt <= '0;
        else if (mem_access)
            access_cnt <= access_cnt + 1'b1;
        else
            access_cnt <= '0;
    end

    // An arrival counts only when its step bit is set
    always_comb
    begin
        arrival_valid = 1'b0;
        for (int k = 0; k < ARRAY_SIZE; k++)
        begin
            if (access_cnt == k + MEM_LATENCY && step_mask[k])
                arrival_valid = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane masking and diagonal skew
    ////////////////////////////////////////////////////////////

    assign skew_clear = reset || !start_mat_mul || step == '0;

    for (genvar n = 0; n < ARRAY_SIZE; n++)
    begin : g_lane
        assign masked[n] = (arrival_valid && lane_mask[n]) ?
                           mem_data[n*DATA_WIDTH +: DATA_WIDTH] : '0;

        if (n == 0)
        begin : g_direct
            // Lane 0 enters the mesh without delay
            assign skewed_lanes[DATA_WIDTH-1:0] = masked[0];
        end
        else
        begin : g_delay
            data_t dly_q [n];

            always_ff @(posedge clk)
            begin
                if (skew_clear)
                begin
                    for (int d = 0; d < n; d++)
                        dly_q[d] <= '0;
                end
                else
                begin
                    dly_q[0] <= masked[n];
                    for (int d = 1; d < n; d++)
                        dly_q[d] <= dly_q[d-1];
                end
            end

            assign skewed_lanes[n*DATA_WIDTH +: DATA_WIDTH] = dly_q[n-1];
        end
    end

    a_access_bounded : assert property (
        @(posedge clk) disable iff (reset)
        access_cnt <= ARRAY_SIZE
    );

endmodule

`default_nettype wire

// File: mac_pe.sv
`default_nettype none

module mac_pe
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  clear,
    input  data_t in_a,
    input  data_t in_b,
    output data_t out_a,
    output data_t out_b,
    output data_t acc
);

    data_t prod_q;

    ////////////////////////////////////////////////////////////
    // Forwarding registers and three-stage MAC
    ////////////////////////////////////////////////////////////

    // The forwarding registers double as the MAC operand stage, since
    // both capture the same inputs on the same edge
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            out_a  <= '0;
            out_b  <= '0;
            prod_q <= '0;
            acc    <= '0;
        end
        else
        begin
            out_a  <= in_a;
            out_b  <= in_b;
            // Product and sum keep only the low byte, wrapping modulo 256
            prod_q <= data_t'(out_a * out_b);
            acc    <= acc + prod_q;
        end
    end

endmodule

`default_nettype wire

// File: pe_array.sv
`default_nettype none

module pe_array
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  lane_vec_t a_lanes,
    input  lane_vec_t b_lanes,
    output lane_vec_t c_col0,
    output lane_vec_t c_col1,
    output lane_vec_t c_col2,
    output lane_vec_t c_col3
);

    logic      pe_clear;
    // Column ARRAY_SIZE of a_bus and row ARRAY_SIZE of b_bus are the
    // east and south edges, which have no consumer in a single tile
    data_t     a_bus [ARRAY_SIZE][ARRAY_SIZE+1];
    data_t     b_bus [ARRAY_SIZE+1][ARRAY_SIZE];
    data_t     sum   [ARRAY_SIZE][ARRAY_SIZE];
    lane_vec_t col_sums [ARRAY_SIZE];

    // Accumulators start from zero on every new operation
    assign pe_clear = reset || !start_mat_mul;

    ////////////////////////////////////////////////////////////
    // Mesh of processing elements
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_row
        assign a_bus[i][0] = a_lanes[i*DATA_WIDTH +: DATA_WIDTH];
        assign b_bus[0][i] = b_lanes[i*DATA_WIDTH +: DATA_WIDTH];

        for (genvar j = 0; j < ARRAY_SIZE; j++)
        begin : g_col
            mac_pe u_pe (
                .clk   (clk),
                .clear (pe_clear),
                .in_a  (a_bus[i][j]),
                .in_b  (b_bus[i][j]),
                .out_a (a_bus[i][j+1]),
                .out_b (b_bus[i+1][j]),
                .acc   (sum[i][j])
            );
        end
    end

    // Column j carries C[i][j] in lane i
    always_comb
    begin
        for (int j = 0; j < ARRAY_SIZE; j++)
        begin
            for (int i = 0; i < ARRAY_SIZE; i++)
                col_sums[j][i*DATA_WIDTH +: DATA_WIDTH] = sum[i][j];
        end
    end

    assign c_col0 = col_sums[0];
    assign c_col1 = col_sums[1];
    assign c_col2 = col_sums[2];
    assign c_col3 = col_sums[3];

endmodule

`default_nettype wire

// File: result_drain.sv
`default_nettype none

module result_drain
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  step_t     step,
    input  addr_t     c_base_addr,
    input  stride_t   c_stride,
    input  lane_vec_t c_col0,
    input  lane_vec_t c_col1,
    input  lane_vec_t c_col2,
    input  lane_vec_t c_col3,
    output lane_vec_t c_data_out,
    output addr_t     c_addr,
    output logic      c_data_available
);

    drain_state_t                  state;
    logic [$clog2(ARRAY_SIZE)-1:0] col_cnt;
    // Columns still waiting behind the one on c_data_out
    lane_vec_t                     hold_q [ARRAY_SIZE-1];

    ////////////////////////////////////////////////////////////
    // Capture and shift-out FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            state            <= DRAIN_IDLE;
            col_cnt          <= '0;
            c_data_available <= 1'b0;
            c_addr           <= c_base_addr - addr_t'(c_stride);
            c_data_out       <= '0;
            for (int k = 0; k < ARRAY_SIZE - 1; k++)
                hold_q[k] <= '0;
        end
        else
        begin
            case (state)
                DRAIN_IDLE:
                begin
                    if (step == step_t'(ROW_LATCH_STEP))
                    begin
                        // All sums are final, column 0 goes out first
                        state            <= DRAIN_SHIFT;
                        col_cnt          <= '0;
                        c_data_available <= 1'b1;
                        c_addr           <= c_addr + addr_t'(c_stride);
                        c_data_out       <= c_col0;
                        hold_q[0]        <= c_col1;
                        hold_q[1]        <= c_col2;
                        hold_q[2]        <= c_col3;
                    end
                end

                DRAIN_SHIFT:
                begin
                    // Zeros fill in behind the last column
                    c_data_out <= hold_q[0];
                    for (int k = 0; k < ARRAY_SIZE - 2; k++)
                        hold_q[k] <= hold_q[k+1];
                    hold_q[ARRAY_SIZE-2] <= '0;

                    if (col_cnt == ARRAY_SIZE - 1)
                    begin
                        state            <= DRAIN_IDLE;
                        c_data_available <= 1'b0;
                        c_addr           <= c_base_addr - addr_t'(c_stride);
                    end
                    else
                    begin
                        col_cnt <= col_cnt + 1'b1;
                        c_addr  <= c_addr + addr_t'(c_stride);
                    end
                end

                default:
                    state <= DRAIN_IDLE;
            endcase
        end
    end

    // An abort clears the output on the following edge
    a_avail_needs_start : assert property (
        @(posedge clk) disable iff (reset)
        c_data_available |-> $past(start_mat_mul)
    );

endmodule

`default_nettype wire

// File: matmul_4x4_top.sv
`default_nettype none

module matmul_4x4_top
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  addr_t     address_mat_a,
    input  addr_t     address_mat_b,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_a,
    input  stride_t   address_stride_b,
    input  stride_t   address_stride_c,
    input  lane_vec_t a_data,
    input  lane_vec_t b_data,
    input  mask_t     validity_mask_a_rows,
    input  mask_t     validity_mask_a_cols_b_rows,
    input  mask_t     validity_mask_b_cols,
    output addr_t     a_addr,
    output addr_t     b_addr,
    output addr_t     c_addr,
    output lane_vec_t c_data_out,
    output logic      c_data_available,
    output logic      done_mat_mul
);

    step_t     step;
    lane_vec_t a_lanes;
    lane_vec_t b_lanes;
    lane_vec_t c_col0;
    lane_vec_t c_col1;
    lane_vec_t c_col2;
    lane_vec_t c_col3;

    matmul_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .step          (step),
        .done_mat_mul  (done_mat_mul)
    );

    ////////////////////////////////////////////////////////////
    // Operand feeders
    ////////////////////////////////////////////////////////////

    // A reads columns, so its lane mask is the row mask
    operand_feeder u_feed_a (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .step          (step),
        .base_addr     (address_mat_a),
        .addr_stride   (address_stride_a),
        .mem_data      (a_data),
        .step_mask     (validity_mask_a_cols_b_rows),
        .lane_mask     (validity_mask_a_rows),
        .mem_addr      (a_addr),
        .skewed_lanes  (a_lanes)
    );

    // B reads rows, so its lane mask is the column mask
    operand_feeder u_feed_b (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .step          (step),
        .base_addr     (address_mat_b),
        .addr_stride   (address_stride_b),
        .mem_data      (b_data),
        .step_mask     (validity_mask_a_cols_b_rows),
        .lane_mask     (validity_mask_b_cols),
        .mem_addr      (b_addr),
        .skewed_lanes  (b_lanes)
    );

    pe_array u_pe_array (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .a_lanes       (a_lanes),
        .b_lanes       (b_lanes),
        .c_col0        (c_col0),
        .c_col1        (c_col1),
        .c_col2        (c_col2),
        .c_col3        (c_col3)
    );

    result_drain u_drain (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .step             (step),
        .c_base_addr      (address_mat_c),
        .c_stride         (address_stride_c),
        .c_col0           (c_col0),
        .c_col1           (c_col1),
        .c_col2           (c_col2),
        .c_col3           (c_col3),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // Reset is synchronous, so it is released on a rising edge
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_matmul.sv
`default_nettype none

module tb_matmul
    import matmul_pkg::*;
();

    localparam int MEM_DEPTH      = 1 << ADDR_WIDTH;
    localparam int TIMEOUT_CYCLES = 100;
    // Result columns leave in steps 15 to 18 and done comes in step 18
    localparam int FIRST_OUT_STEP = 15;
    localparam int DONE_AT_STEP   = 18;

    logic      clk;
    logic      reset;
    logic      start_mat_mul;
    addr_t     address_mat_a;
    addr_t     address_mat_b;
    addr_t     address_mat_c;
    stride_t   address_stride_a;
    stride_t   address_stride_b;
    stride_t   address_stride_c;
    lane_vec_t a_data = '0;
    lane_vec_t b_data = '0;
    mask_t     validity_mask_a_rows;
    mask_t     validity_mask_a_cols_b_rows;
    mask_t     validity_mask_b_cols;
    addr_t     a_addr;
    addr_t     b_addr;
    addr_t     c_addr;
    lane_vec_t c_data_out;
    logic      c_data_available;
    logic      done_mat_mul;

    // Memory models and the operation being prepared
    lane_vec_t mem_a [MEM_DEPTH];
    lane_vec_t mem_b [MEM_DEPTH];
    data_t     mat_a [ARRAY_SIZE][ARRAY_SIZE];
    data_t     mat_b [ARRAY_SIZE][ARRAY_SIZE];
    lane_vec_t exp_c [ARRAY_SIZE];
    addr_t     cfg_a_base;
    addr_t     cfg_b_base;
    addr_t     cfg_c_base;
    stride_t   cfg_a_stride;
    stride_t   cfg_b_stride;
    stride_t   cfg_c_stride;
    mask_t     cfg_row_mask;
    mask_t     cfg_step_mask;
    mask_t     cfg_col_mask;

    // Step of the running operation as seen from the start level, -1 when idle
    int        run_step;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    matmul_4x4_top dut (
        .clk                         (clk),
        .reset                       (reset),
        .start_mat_mul               (start_mat_mul),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_mat_c               (address_mat_c),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .address_stride_c            (address_stride_c),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .c_addr                      (c_addr),
        .c_data_out                  (c_data_out),
        .c_data_available            (c_data_available),
        .done_mat_mul                (done_mat_mul)
    );

    // One-cycle read latency on both memories
    always @(posedge clk)
    begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////

    function automatic addr_t stride_addr(input addr_t base, input stride_t stride, input int k);
        return addr_t'(int'(base) + k * int'(stride));
    endfunction

    // Column col of C, lane i holding C[i][col] modulo 256
    function automatic lane_vec_t ref_matmul(input int col);
        lane_vec_t column;
        int        sum;
        column = '0;
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            sum = 0;
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                if (cfg_step_mask[k] && cfg_row_mask[i] && cfg_col_mask[col])
                    sum = sum + int'(mat_a[i][k]) * int'(mat_b[k][col]);
            end
            column[i*DATA_WIDTH +: DATA_WIDTH] = data_t'(sum);
        end
        return column;
    endfunction

    task automatic stop_on_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_lanes(input lane_vec_t actual, input lane_vec_t expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("error: time %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input addr_t actual, input addr_t expected, input string what);
        if (actual !== expected)
        begin
            $display("error: time %0t: %s is %h, expected %h", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("error: time %0t: %s is %b, expected %b", $time, what, actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic compare_outputs();
        logic avail_exp;
        int   col;
        avail_exp = (run_step >= FIRST_OUT_STEP) && (run_step < FIRST_OUT_STEP + ARRAY_SIZE);
        check_flag(c_data_available, avail_exp, "c_data_available");
        check_flag(done_mat_mul, run_step == DONE_AT_STEP, "done_mat_mul");

        if (avail_exp)
        begin
            col = run_step - FIRST_OUT_STEP;
            check_lanes(c_data_out, exp_c[col], "c_data_out");
            check_addr(c_addr, stride_addr(address_mat_c, address_stride_c, col), "c_addr");
        end
        else
            check_lanes(c_data_out, '0, "c_data_out while idle");

        if (run_step >= 0 && run_step < FIRST_OUT_STEP)
            check_addr(c_addr, stride_addr(address_mat_c, address_stride_c, -1),
                       "c_addr before output");

        // Reads go out in steps 1 to 4, base minus stride otherwise
        if (run_step >= 1 && run_step <= ARRAY_SIZE)
        begin
            check_addr(a_addr, stride_addr(address_mat_a, address_stride_a, run_step - 1),
                       "a_addr");
            check_addr(b_addr, stride_addr(address_mat_b, address_stride_b, run_step - 1),
                       "b_addr");
        end
        else if (run_step == 0 || (run_step > ARRAY_SIZE && run_step <= DONE_AT_STEP))
        begin
            check_addr(a_addr, stride_addr(address_mat_a, address_stride_a, -1),
                       "a_addr while idle");
            check_addr(b_addr, stride_addr(address_mat_b, address_stride_b, -1),
                       "b_addr while idle");
        end
    endtask

    // Outputs are sampled on the falling edge, away from the DUT's updates
    initial
    begin
        run_step = -1;
        forever
        begin
            @(negedge clk);
            if (!start_mat_mul)
                run_step = -1;
            else
                run_step = run_step + 1;
            if (!reset)
                compare_outputs();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic fill_memories();
        for (int n = 0; n < MEM_DEPTH; n++)
        begin
            mem_a[n] = lane_vec_t'(32'(n) * 32'h9e37_79b1);
            mem_b[n] = lane_vec_t'(~(32'(n) * 32'h85eb_ca6b));
        end
    endtask

    task automatic pick_operation(input bit unit_layout, input bit random_masks);
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                mat_a[i][k] = data_t'($urandom);
                mat_b[i][k] = data_t'($urandom);
            end
        end

        if (unit_layout)
        begin
            cfg_a_base   = '0;
            cfg_b_base   = '0;
            cfg_c_base   = '0;
            cfg_a_stride = stride_t'(1);
            cfg_b_stride = stride_t'(1);
            cfg_c_stride = stride_t'(1);
        end
        else
        begin
            cfg_a_base   = addr_t'($urandom);
            cfg_b_base   = addr_t'($urandom);
            cfg_c_base   = addr_t'($urandom);
            cfg_a_stride = stride_t'($urandom_range(255, 1));
            cfg_b_stride = stride_t'($urandom_range(255, 1));
            cfg_c_stride = stride_t'($urandom_range(255, 1));
        end

        if (random_masks)
        begin
            cfg_row_mask  = mask_t'($urandom);
            cfg_step_mask = mask_t'($urandom);
            cfg_col_mask  = mask_t'($urandom);
        end
        else
        begin
            cfg_row_mask  = '1;
            cfg_step_mask = '1;
            cfg_col_mask  = '1;
        end
    endtask

    task automatic apply_config();
        address_mat_a               <= cfg_a_base;
        address_mat_b               <= cfg_b_base;
        address_mat_c               <= cfg_c_base;
        address_stride_a            <= cfg_a_stride;
        address_stride_b            <= cfg_b_stride;
        address_stride_c            <= cfg_c_stride;
        validity_mask_a_rows        <= cfg_row_mask;
        validity_mask_a_cols_b_rows <= cfg_step_mask;
        validity_mask_b_cols        <= cfg_col_mask;
    endtask

    // Word k of A is column k, word k of B is row k
    task automatic load_operation();
        lane_vec_t word_a;
        lane_vec_t word_b;
        for (int k = 0; k < ARRAY_SIZE; k++)
        begin
            for (int n = 0; n < ARRAY_SIZE; n++)
            begin
                word_a[n*DATA_WIDTH +: DATA_WIDTH] = mat_a[n][k];
                word_b[n*DATA_WIDTH +: DATA_WIDTH] = mat_b[k][n];
            end
            mem_a[stride_addr(cfg_a_base, cfg_a_stride, k)] = word_a;
            mem_b[stride_addr(cfg_b_base, cfg_b_stride, k)] = word_b;
        end
        for (int j = 0; j < ARRAY_SIZE; j++)
            exp_c[j] = ref_matmul(j);
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done_mat_mul && cycles < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!done_mat_mul)
        begin
            $display("Timed out waiting for done_mat_mul");
            stop_on_failure();
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        if (reset)
        begin
            $display("Timed out waiting for reset to be released");
            stop_on_failure();
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) @(posedge clk);
    endtask

    // Expects start low and the configuration already applied
    task automatic launch_and_wait();
        @(negedge clk);
        load_operation();
        @(posedge clk);
        start_mat_mul <= 1'b1;
        wait_done();
    endtask

    task automatic run_operation();
        @(posedge clk);
        apply_config();
        launch_and_wait();
        @(posedge clk);
        start_mat_mul <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        start_mat_mul               = 1'b0;
        address_mat_a               = '0;
        address_mat_b               = '0;
        address_mat_c               = '0;
        address_stride_a            = '0;
        address_stride_b            = '0;
        address_stride_c            = '0;
        validity_mask_a_rows        = '0;
        validity_mask_a_cols_b_rows = '0;
        validity_mask_b_cols        = '0;
        void'($urandom(32'hd3a));
        fill_memories();
        wait_reset_release();
        idle_cycles(3);

        // Unit strides with every lane and step enabled
        repeat (2)
        begin
            pick_operation(1'b1, 1'b0);
            run_operation();
            idle_cycles(2);
        end

        // Random row, step and column masks
        repeat (4)
        begin
            pick_operation(1'b1, 1'b1);
            run_operation();
            idle_cycles(2);
        end

        // Nonzero bases with assorted strides, some masked as well
        repeat (4)
        begin
            pick_operation(1'b0, 1'b0);
            run_operation();
            idle_cycles(3);
        end
        pick_operation(1'b0, 1'b1);
        run_operation();
        idle_cycles(2);

        // Two operations with a single idle cycle between them
        pick_operation(1'b0, 1'b0);
        @(posedge clk);
        apply_config();
        launch_and_wait();
        pick_operation(1'b0, 1'b0);
        @(posedge clk);
        start_mat_mul <= 1'b0;
        apply_config();
        launch_and_wait();
        @(posedge clk);
        start_mat_mul <= 1'b0;

        idle_cycles(4);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
matmul_pkg.sv
matmul_sequencer.sv
operand_feeder.sv
mac_pe.sv
pe_array.sv
result_drain.sv
matmul_4x4_top.sv
tb_clock_gen.sv
tb_matmul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_matmul \
    -f project.f -Mdir obj_dir > "$LOG" 2>&1 \
    && ./obj_dir/Vtb_matmul >> "$LOG" 2>&1
status=$?

grep -q "Finished with errors" "$LOG" && { echo "Simulation failed"; exit 1; }
[ "$status" -eq 0 ] || { echo "Build or run failed, see $LOG"; exit 1; }
grep -q "Finished with no errors" "$LOG" || { echo "Pass message missing in $LOG"; exit 1; }
echo "Simulation passed"
